/* source/rename_pkg.sv */
package rename_pkg;

    localparam int arch_regs        = 32;
    localparam int phys_regs        = 64;
    localparam int checkpoint_pages = 8;

    localparam int logical_w = $clog2(arch_regs);
    localparam int tag_w     = $clog2(phys_regs);
    localparam int page_w    = $clog2(checkpoint_pages);

    typedef logic [logical_w-1:0] logical_idx_t;
    typedef logic [tag_w-1:0]     phys_tag_t;
    typedef logic [page_w-1:0]    page_idx_t;
    typedef logic [tag_w:0]       free_ptr_t;   // extra bit tells full from empty
    typedef logic [6:0]           opcode_t;

    typedef phys_tag_t [arch_regs-1:0] alias_map_t;

    localparam opcode_t op_lui    = 7'b0110111; // no sources
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111; // rs1 only
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_branch = 7'b1100011; // no destination
    localparam opcode_t op_store  = 7'b0100011;

    typedef union packed {
        struct packed {
            logic [6:0]   funct7;
            logical_idx_t rs2;
            logical_idx_t rs1;
            logic [2:0]   funct3;
            logical_idx_t rd;
            opcode_t      opcode;
        } reg_view;
        struct packed {
            logic [19:0]  imm20;
            logical_idx_t rd;
            opcode_t      opcode;
        } upper_view;
    } instr_u;

    typedef struct packed {
        logic   valid;
        instr_u instr;
    } rename_req_t;

    typedef struct packed {
        logic      valid;
        logic      src1_used;
        phys_tag_t src1_tag;
        logic      src2_used;
        phys_tag_t src2_tag;
        logic      rd_write;
        phys_tag_t rd_tag;
        phys_tag_t old_tag;      // released later at commit
    } rename_rsp_t;

    typedef struct packed {
        logic      save;
        logic      restore;
        page_idx_t save_page;
        page_idx_t restore_page;
    } checkpoint_t;

endpackage

/* source/rename_classify.sv */
`timescale 1ns/1ps

module rename_classify import rename_pkg::*; (
    input  instr_u instr,
    output logic   uses_rs1,
    output logic   uses_rs2,
    output logic   writes_rd
);

    opcode_t opcode;
    logic    u_type;
    logic    no_dest;
    logic    rd_is_x0;

    assign opcode = instr.reg_view.opcode;

    // lui and auipc hold imm20 where the source fields would sit
    assign u_type = (instr.upper_view.opcode == op_lui) ||
                    (instr.upper_view.opcode == op_auipc);

    always_comb begin
        uses_rs1 = 1'b1;                          // r-type and default
        uses_rs2 = 1'b1;
        if (u_type || (opcode == op_jal)) begin
            uses_rs1 = 1'b0;                      // no register sources
            uses_rs2 = 1'b0;
        end else if (opcode inside {op_jalr, op_load, op_imm}) begin
            uses_rs2 = 1'b0;                      // immediate replaces rs2
        end
    end

    assign no_dest  = (opcode == op_branch) || (opcode == op_store);
    assign rd_is_x0 = (instr.upper_view.rd == '0); // same bits in both views

    // x0 keeps its reset mapping for good
    assign writes_rd = !no_dest && !rd_is_x0;

endmodule

/* source/register_alias_table.sv */
`timescale 1ns/1ps

module register_alias_table import rename_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  rename_req_t req,
    input  logic        uses_rs1,
    input  logic        uses_rs2,
    input  logic        writes_rd,
    input  checkpoint_t ckpt,
    input  phys_tag_t   head_tag,
    input  logic        empty,
    output logic        alloc,
    output rename_rsp_t rsp
);

    alias_map_t   map_q;
    alias_map_t   map_next;
    alias_map_t   reset_map;
    alias_map_t   page_q [checkpoint_pages];
    logical_idx_t rs1;
    logical_idx_t rs2;
    logical_idx_t rd;

    assign rs1 = req.instr.reg_view.rs1;
    assign rs2 = req.instr.reg_view.rs2;
    assign rd  = req.instr.reg_view.rd;

    assign alloc = req.valid && writes_rd;       // pop strobe to the free list

    // identity map, logical i on physical i
    always_comb begin
        for (int i = 0; i < arch_regs; i++) begin
            reset_map[i] = phys_tag_t'(i);
        end
    end

    // table after this cycle's remap
    always_comb begin
        map_next = map_q;
        if (alloc) begin
            map_next[rd] = head_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            map_q <= reset_map;
        end else if (ckpt.restore) begin
            map_q <= page_q[ckpt.restore_page]; // seen by next cycle's lookups
        end else begin
            map_q <= map_next;
        end
    end

    // a save includes the rename of the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < checkpoint_pages; p++) begin
                page_q[p] <= reset_map;
            end
        end else if (ckpt.save) begin
            page_q[ckpt.save_page] <= map_next;
        end
    end

    // response one cycle after the request, sources read before the remap
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.valid;
        end
        rsp.src1_used <= uses_rs1;
        rsp.src1_tag  <= uses_rs1 ? map_q[rs1] : '0;
        rsp.src2_used <= uses_rs2;
        rsp.src2_tag  <= uses_rs2 ? map_q[rs2] : '0;
        rsp.rd_write  <= writes_rd;
        rsp.rd_tag    <= writes_rd ? head_tag : '0;
        rsp.old_tag   <= writes_rd ? map_q[rd] : '0;  // freed when this one commits
    end

    // rollback never shares a cycle with a rename or a save
    restore_alone: assert property (
        @(posedge clk) disable iff (reset)
        ckpt.restore |-> !req.valid && !ckpt.save
    ) else $error("restore overlaps a request or a save");

    // sender must hold tag-needing requests while the free list is dry
    no_alloc_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        alloc |-> !empty
    ) else $error("tag allocated from an empty free list");

endmodule

/* source/free_list.sv */
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        alloc,
    input  checkpoint_t ckpt,
    input  logic        commit_valid,
    input  phys_tag_t   commit_tag,
    output phys_tag_t   head_tag,
    output logic        empty
);

    phys_tag_t queue_q [phys_regs];
    free_ptr_t saved_q [checkpoint_pages];
    free_ptr_t rd_ptr_q;
    free_ptr_t rd_ptr_next;
    free_ptr_t wr_ptr_q;
    logic      full;

    assign rd_ptr_next = alloc ? rd_ptr_q + free_ptr_t'(1) : rd_ptr_q;

    assign empty = (rd_ptr_q == wr_ptr_q);
    assign full  = (rd_ptr_q[tag_w-1:0] == wr_ptr_q[tag_w-1:0]) &&
                   (rd_ptr_q[tag_w] != wr_ptr_q[tag_w]);

    assign head_tag = queue_q[rd_ptr_q[tag_w-1:0]];   // next tag handed out

    // upper half of the tags starts free, in ascending order
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < phys_regs; i++) begin
                queue_q[i] <= phys_tag_t'(i + arch_regs);
            end
        end else if (commit_valid) begin
            queue_q[wr_ptr_q[tag_w-1:0]] <= commit_tag;  // push at tail
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= free_ptr_t'(phys_regs - arch_regs);
        end else begin
            if (ckpt.restore) begin
                rd_ptr_q <= saved_q[ckpt.restore_page];  // rewind head
            end else begin
                rd_ptr_q <= rd_ptr_next;
            end
            if (commit_valid) begin
                wr_ptr_q <= wr_ptr_q + free_ptr_t'(1);
            end
        end
    end

    // saved head is taken after this cycle's pop
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < checkpoint_pages; p++) begin
                saved_q[p] <= '0;
            end
        end else if (ckpt.save) begin
            saved_q[ckpt.save_page] <= rd_ptr_next;
        end
    end

    // only tags taken from this list ever come back
    no_commit_overflow: assert property (
        @(posedge clk) disable iff (reset)
        commit_valid |-> !full
    ) else $error("commit pushed into a full free list");

endmodule

/* source/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  rename_req_t req,
    input  checkpoint_t ckpt,
    input  logic        commit_valid,
    input  phys_tag_t   commit_tag,
    output rename_rsp_t rsp,
    output logic        free_empty
);

    logic      uses_rs1;
    logic      uses_rs2;
    logic      writes_rd;
    logic      alloc;
    phys_tag_t head_tag;

    // opcode groups to source and destination flags
    rename_classify u_classify (
        .instr     (req.instr),
        .uses_rs1  (uses_rs1),
        .uses_rs2  (uses_rs2),
        .writes_rd (writes_rd)
    );

    register_alias_table u_rat (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .uses_rs1  (uses_rs1),
        .uses_rs2  (uses_rs2),
        .writes_rd (writes_rd),
        .ckpt      (ckpt),
        .head_tag  (head_tag),
        .empty     (free_empty),
        .alloc     (alloc),
        .rsp       (rsp)
    );

    // head tag every cycle, popped on alloc
    free_list u_free_list (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .ckpt         (ckpt),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .head_tag     (head_tag),
        .empty        (free_empty)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam realtime half_period = 4.0ns;  // 8 ns clock
    localparam int      reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;                      // released on an edge
    end

endmodule

/* test/rename_checker.sv */
`timescale 1ns/1ps

module rename_checker import rename_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  rename_req_t req,
    input  checkpoint_t ckpt,
    input  logic        commit_valid,
    input  phys_tag_t   commit_tag,
    input  rename_rsp_t rsp,
    input  logic        free_empty,
    output int          check_count,
    output int          error_count
);

    phys_tag_t   table_m [arch_regs];
    phys_tag_t   pages_m [checkpoint_pages][arch_regs];
    phys_tag_t   queue_m [phys_regs];
    int unsigned saved_m [checkpoint_pages];
    int unsigned rd_m;                      // free-running, never wraps in a run
    int unsigned wr_m;
    rename_rsp_t exp_rsp;
    logic        exp_pending;

    // {reads rs1, reads rs2, writes rd} per opcode group
    function automatic logic [2:0] usage(input logic [31:0] word);
        logic dest;
        dest = (word[11:7] != 5'd0) && (word[6:0] != op_branch) && (word[6:0] != op_store);
        case (word[6:0])
            op_lui, op_auipc, op_jal: return {2'b00, dest};
            op_jalr, op_load, op_imm: return {2'b10, dest};
            default:                  return {2'b11, dest};
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic check_field(input string name, input int got, input int want);
        if (got != want) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", name, got, want));
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < arch_regs; i++) begin
            table_m[i] = phys_tag_t'(i);
            queue_m[i] = phys_tag_t'(arch_regs + i);   // upper half starts free
        end
        for (int p = 0; p < checkpoint_pages; p++) begin
            pages_m[p] = table_m;
            saved_m[p] = 0;
        end
        rd_m        = 0;
        wr_m        = arch_regs;
        exp_pending = 1'b0;
        exp_rsp     = '0;
        check_count = 0;
        error_count = 0;
    endtask

    task automatic compare_rsp();
        if (rsp.valid !== exp_pending) begin
            report_mismatch($sformatf("rsp.valid is %b, expected %b", rsp.valid, exp_pending));
        end else if (exp_pending) begin
            check_count++;
            check_field("src1_used", int'(rsp.src1_used), int'(exp_rsp.src1_used));
            check_field("src2_used", int'(rsp.src2_used), int'(exp_rsp.src2_used));
            check_field("rd_write", int'(rsp.rd_write), int'(exp_rsp.rd_write));
            if (exp_rsp.src1_used) begin
                check_field("src1_tag", int'(rsp.src1_tag), int'(exp_rsp.src1_tag));
            end
            if (exp_rsp.src2_used) begin
                check_field("src2_tag", int'(rsp.src2_tag), int'(exp_rsp.src2_tag));
            end
            if (exp_rsp.rd_write) begin
                check_field("rd_tag", int'(rsp.rd_tag), int'(exp_rsp.rd_tag));
                check_field("old_tag", int'(rsp.old_tag), int'(exp_rsp.old_tag));
            end
        end
    endtask

    always @(posedge clk) begin
        logic [31:0] word;
        logic [2:0]  use_f;
        logic [4:0]  rd;
        if (reset) begin
            reset_model();
        end else begin
            compare_rsp();                      // request of the previous edge
            check_field("free_empty", int'(free_empty), int'(rd_m == wr_m));
            word        = req.instr;
            exp_pending = req.valid;
            exp_rsp     = '0;
            if (req.valid) begin
                use_f             = usage(word);
                rd                = word[11:7];
                exp_rsp.valid     = 1'b1;
                exp_rsp.src1_used = use_f[2];
                exp_rsp.src1_tag  = table_m[word[19:15]];   // table before own remap
                exp_rsp.src2_used = use_f[1];
                exp_rsp.src2_tag  = table_m[word[24:20]];
                exp_rsp.rd_write  = use_f[0];
                if (use_f[0]) begin
                    exp_rsp.rd_tag  = queue_m[phys_tag_t'(rd_m)];
                    exp_rsp.old_tag = table_m[rd];
                    table_m[rd]     = exp_rsp.rd_tag;
                    rd_m++;
                end
            end
            if (ckpt.save) begin
                pages_m[ckpt.save_page] = table_m;  // includes this cycle's rename
                saved_m[ckpt.save_page] = rd_m;
            end
            if (ckpt.restore) begin
                table_m = pages_m[ckpt.restore_page];
                rd_m    = saved_m[ckpt.restore_page];
            end
            if (commit_valid) begin
                queue_m[phys_tag_t'(wr_m)] = commit_tag;
                wr_m++;
            end
        end
    end

endmodule

/* test/rename_tb.sv */
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    localparam opcode_t op_alu = 7'b0110011;
    localparam opcode_t op_list [9] = '{op_lui, op_auipc, op_jal, op_jalr, op_load,
                                        op_imm, op_branch, op_store, op_alu};
    localparam int random_len  = 2000;
    localparam int stim_cycles = 4 + 17 + 18 + 20 + 22 + 48 + random_len + 6 * 3;
    localparam int cycle_limit = 4 * stim_cycles;

    logic        clk;
    logic        reset;
    rename_req_t req;
    checkpoint_t ckpt;
    logic        commit_valid;
    phys_tag_t   commit_tag;
    rename_rsp_t rsp;
    logic        free_empty;
    int          check_count;
    int          error_count;
    int          sh_rd;                     // free-list pointers as seen by the sender
    int          sh_wr;
    int          sh_saved [checkpoint_pages];
    phys_tag_t   pending [$];               // old tags waiting to retire
    int          tests_run;
    int          failed_tests;
    int          cycle_count = 0;

    tb_clock_gen u_clk_gen (.clk(clk), .reset(reset));

    rename_stage u_dut (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .ckpt         (ckpt),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .rsp          (rsp),
        .free_empty   (free_empty)
    );

    rename_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .ckpt         (ckpt),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .rsp          (rsp),
        .free_empty   (free_empty),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    function automatic logic [31:0] random_instr();
        logic [31:0] word;
        int          idx;
        word = $urandom;
        idx  = $urandom_range(9, 0);
        if (idx < 9) begin
            word[6:0] = op_list[idx];       // else an arbitrary opcode
        end
        return word;
    endfunction

    function automatic logic [31:0] alu_word();
        logic [31:0] word;
        word      = $urandom;
        word[6:0] = op_alu;
        return word;
    endfunction

    // one clock of stimulus, trimmed to what the stage may legally take
    task automatic drive_cycle(input logic want_req, input logic [31:0] word,
                               input checkpoint_t want_ck, input logic want_commit);
        checkpoint_t ck;
        logic        pops;
        logic        restore_ok;
        logic        do_req;
        logic        do_commit;
        int          rd_after;
        @(posedge clk);
        ck         = want_ck;
        restore_ok = ck.restore && (sh_wr - sh_saved[ck.restore_page] <= phys_regs);
        ck.restore = restore_ok;
        if (restore_ok) begin
            ck.save = 1'b0;                 // rollback stands alone
        end
        rd_after  = restore_ok ? sh_saved[ck.restore_page] : sh_rd;  // head after this edge
        pops = (word[11:7] != 5'd0) && (word[6:0] != op_branch) &&
               (word[6:0] != op_store);
        do_req    = want_req && !restore_ok && !(pops && sh_wr == sh_rd);
        do_commit = want_commit && (pending.size() > 0) && (sh_wr - rd_after < phys_regs);
        req.valid    <= do_req;
        req.instr    <= word;
        ckpt         <= ck;
        commit_valid <= do_commit;
        if (do_commit) begin
            commit_tag <= pending.pop_front();
        end else begin
            commit_tag <= '0;
        end
        if (restore_ok) begin
            sh_rd = sh_saved[ck.restore_page];
        end else if (do_req && pops) begin
            sh_rd++;
        end
        if (ck.save) begin
            sh_saved[ck.save_page] = sh_rd;
        end
        if (do_commit) begin
            sh_wr++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        int errors;
        drive_cycle(1'b0, '0, '0, 1'b0);
        drive_cycle(1'b0, '0, '0, 1'b0);
        @(negedge clk);                     // last response compared by now
        errors = error_count - errors_before;
        tests_run++;
        if (errors == 0) begin
            $display("%0t %s: ok", $time, name);
        end else begin
            failed_tests++;
            $display("%0t %s: %0d mismatches", $time, name, errors);
        end
    endtask

    // retired mappings become the tags that later commits return
    always @(negedge clk) begin
        if (!reset && rsp.valid && rsp.rd_write) begin
            pending.push_back(rsp.old_tag);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        checkpoint_t ck;
        logic [31:0] word;
        int          errors_before;
        void'($urandom(31337));
        req          <= '0;
        ckpt         <= '0;
        commit_valid <= 1'b0;
        commit_tag   <= '0;
        sh_rd        = 0;
        sh_wr        = phys_regs - arch_regs;
        foreach (sh_saved[p]) begin
            sh_saved[p] = 0;
        end
        tests_run    = 0;
        failed_tests = 0;
        wait (reset == 1'b0);
        @(negedge clk);

        errors_before = error_count;        // identity map after reset
        for (int i = 0; i < 16; i++) begin
            drive_cycle(1'b1, {7'd0, 5'(31 - i), 5'(i), 3'd0, 5'd0, op_alu}, '0, 1'b0);
        end
        drive_cycle(1'b1, {7'd0, 5'd2, 5'd1, 3'd0, 5'd1, op_alu}, '0, 1'b0);
        finish_test("reset_lookup", errors_before);

        errors_before = error_count;
        for (int k = 0; k < 9; k++) begin
            word       = $urandom;
            word[6:0]  = op_list[k];
            drive_cycle(1'b1, word, '0, 1'b0);
            word[11:7] = 5'd0;              // x0 destination
            drive_cycle(1'b1, word, '0, 1'b0);
        end
        finish_test("source_usage", errors_before);

        errors_before = error_count;
        repeat (20) drive_cycle(1'b1, alu_word(), '0, 1'b1);
        finish_test("alloc_order", errors_before);

        errors_before = error_count;
        ck           = '0;
        ck.save      = 1'b1;
        ck.save_page = 3'd3;
        drive_cycle(1'b1, alu_word(), ck, 1'b1);
        repeat (12) drive_cycle(1'b1, random_instr(), '0, 1'b1);
        ck              = '0;
        ck.restore      = 1'b1;
        ck.restore_page = 3'd3;
        drive_cycle(1'b0, '0, ck, 1'b0);
        repeat (8) drive_cycle(1'b1, alu_word(), '0, 1'b0);
        finish_test("checkpoint_restore", errors_before);

        errors_before = error_count;
        repeat (8) drive_cycle(1'b0, '0, '0, 1'b1);
        repeat (40) drive_cycle(1'b1, alu_word(), '0, 1'b0);   // drain into recycled tags
        finish_test("commit_return", errors_before);

        errors_before = error_count;
        repeat (random_len) begin
            ck              = '0;
            ck.save         = ($urandom_range(9, 0) == 0);
            ck.save_page    = page_idx_t'($urandom_range(7, 0));
            ck.restore      = ($urandom_range(19, 0) == 0);
            ck.restore_page = page_idx_t'($urandom_range(7, 0));
            drive_cycle($urandom_range(9, 0) < 7, random_instr(), ck,
                        $urandom_range(9, 0) < 5);
        end
        finish_test("random_mix", errors_before);

        $display("summary: %0d tests, %0d failed, %0d responses checked, %0d mismatches",
                 tests_run, failed_tests, check_count, error_count);
        if (failed_tests == 0 && error_count == 0 && check_count > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/rename_pkg.sv
source/rename_classify.sv
source/register_alias_table.sv
source/free_list.sv
source/rename_stage.sv
test/tb_clock_gen.sv
test/rename_checker.sv
test/rename_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := rename_tb
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ok, see $(LOG)"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
